/* source/motion_pkg.sv */
package motion_pkg;

    ////////////////////
    // output view selector
    ////////////////////

    // code 3 is not listed and falls back to the live view
    typedef enum logic [1:0]
    {
        VIEW_LIVE     = 2'd0,
        VIEW_PREVIOUS = 2'd1,
        VIEW_MOTION   = 2'd2
    } view_mode_t;

    ////////////////////
    // sizes and threshold
    ////////////////////

    // gray samples packed into one stream word
    localparam int default_samples_per_word = 4;

    // one gray sample, fixed for luma only video
    localparam int sample_bits = 8;

    // words per frame, one store address each
    localparam int default_frame_words = 16;

    // motion when |live - previous| exceeds this
    localparam int default_motion_threshold = 10;

endpackage

/* source/stream_ctrl.sv */
`timescale 1ns/100ps

module stream_ctrl
    import motion_pkg::*;
#(
    parameter int samples_per_word = default_samples_per_word
)
(
    input  logic                                  pixel_clk,
    input  logic                                  reset,
    input  logic [samples_per_word*sample_bits-1:0] pixel_in_data,
    input  logic                                  pixel_in_user,
    input  logic                                  pixel_in_last,
    input  logic                                  pixel_in_valid,
    input  logic                                  pixel_out_valid,
    input  logic                                  pixel_out_ready,
    output logic                                  pixel_in_ready,
    output logic                                  accept,
    output logic                                  advance,
    output logic [samples_per_word*sample_bits-1:0] live_word,
    output logic                                  stage_user,
    output logic                                  stage_last,
    output logic                                  stage_valid
);

    ////////////////////
    // global stall
    ////////////////////

    // output full and downstream not taking it
    logic stall;

    assign stall = pixel_out_valid & ~pixel_out_ready;
    // whole pipeline moves together
    assign advance = ~stall;
    assign pixel_in_ready = advance;
    // handshake on the input side
    assign accept = advance & pixel_in_valid;

    ////////////////////
    // stage B registers
    ////////////////////

    // valid bit, cleared by reset
    always_ff @(posedge pixel_clk)
    begin
        if (reset)
            stage_valid <= 1'b0;
        else if (advance)
            stage_valid <= accept;
    end

    // live word and sideband, lined up with the store read
    always_ff @(posedge pixel_clk)
    begin
        if (advance)
        begin
            live_word  <= pixel_in_data;
            stage_user <= pixel_in_user;
            stage_last <= pixel_in_last;
        end
    end

endmodule

/* source/frame_store.sv */
`timescale 1ns/100ps

module frame_store
    import motion_pkg::*;
#(
    parameter int samples_per_word = default_samples_per_word,
    parameter int frame_words      = default_frame_words
)
(
    input  logic                                  pixel_clk,
    input  logic                                  reset,
    input  logic                                  accept,
    input  logic                                  pixel_in_user,
    input  logic [samples_per_word*sample_bits-1:0] pixel_in_data,
    output logic [samples_per_word*sample_bits-1:0] previous_word
);

    // at least one address bit even for a tiny store
    localparam int addr_bits = (frame_words > 1) ? $clog2(frame_words) : 1;
    localparam int word_bits = samples_per_word * sample_bits;

    // previous frame, one stream word per entry
    logic [word_bits-1:0] mem [frame_words];

    // position within the current frame
    logic [addr_bits-1:0] addr_count;
    // address used by this word
    logic [addr_bits-1:0] word_addr;

    ////////////////////
    // address generation
    ////////////////////

    // start of frame forces address 0
    assign word_addr = pixel_in_user ? '0 : addr_count;

    always_ff @(posedge pixel_clk)
    begin
        if (reset)
            addr_count <= '0;
        else if (accept)
        begin
            // wrap at the end of the store
            if (word_addr == addr_bits'(frame_words - 1))
                addr_count <= '0;
            else
                addr_count <= word_addr + 1'b1;
        end
    end

    ////////////////////
    // read first memory
    ////////////////////

    // old content out, live word in, same address
    always_ff @(posedge pixel_clk)
    begin
        if (accept)
        begin
            previous_word   <= mem[word_addr];
            mem[word_addr]  <= pixel_in_data;
        end
    end

endmodule

/* source/frame_diff.sv */
`timescale 1ns/100ps

module frame_diff
    import motion_pkg::*;
#(
    parameter int samples_per_word = default_samples_per_word,
    parameter int motion_threshold = default_motion_threshold
)
(
    input  logic [samples_per_word*sample_bits-1:0] live_word,
    input  logic [samples_per_word*sample_bits-1:0] previous_word,
    output logic [samples_per_word*sample_bits-1:0] motion_word
);

    // threshold at sample width
    localparam logic [sample_bits-1:0] threshold = sample_bits'(motion_threshold);

    ////////////////////
    // per sample compare
    ////////////////////

    genvar i;
    generate
        for (i = 0; i < samples_per_word; i = i + 1)
        begin : g_sample
            logic [sample_bits-1:0] live_s;
            logic [sample_bits-1:0] prev_s;
            logic [sample_bits-1:0] abs_diff;

            // lane i of both words
            assign live_s = live_word[i*sample_bits +: sample_bits];
            assign prev_s = previous_word[i*sample_bits +: sample_bits];

            // larger minus smaller, no sign bit needed
            assign abs_diff = (live_s > prev_s) ? (live_s - prev_s) : (prev_s - live_s);

            // strictly above threshold marks motion
            assign motion_word[i*sample_bits +: sample_bits] =
                (abs_diff > threshold) ? {sample_bits{1'b1}} : {sample_bits{1'b0}};
        end
    endgenerate

endmodule

/* source/view_select.sv */
`timescale 1ns/100ps

module view_select
    import motion_pkg::*;
#(
    parameter int samples_per_word = default_samples_per_word
)
(
    input  logic                                  pixel_clk,
    input  logic                                  reset,
    input  logic                                  advance,
    input  view_mode_t                            view_mode,
    input  logic [samples_per_word*sample_bits-1:0] live_word,
    input  logic [samples_per_word*sample_bits-1:0] previous_word,
    input  logic [samples_per_word*sample_bits-1:0] motion_word,
    input  logic                                  stage_user,
    input  logic                                  stage_last,
    input  logic                                  stage_valid,
    output logic [samples_per_word*sample_bits-1:0] pixel_out_data,
    output logic                                  pixel_out_user,
    output logic                                  pixel_out_last,
    output logic                                  pixel_out_valid
);

    ////////////////////
    // output register
    ////////////////////

    // valid follows stage B whenever the pipe moves
    always_ff @(posedge pixel_clk)
    begin
        if (reset)
            pixel_out_valid <= 1'b0;
        else if (advance)
            pixel_out_valid <= stage_valid;
    end

    // word picked by view, sideband passed along
    always_ff @(posedge pixel_clk)
    begin
        if (advance)
        begin
            case (view_mode)
                VIEW_PREVIOUS: pixel_out_data <= previous_word;
                VIEW_MOTION:   pixel_out_data <= motion_word;
                // live view, also for the unused code
                default:       pixel_out_data <= live_word;
            endcase
            pixel_out_user <= stage_user;
            pixel_out_last <= stage_last;
        end
    end

endmodule

/* source/motion_detect_top.sv */
`timescale 1ns/100ps

module motion_detect_top
    import motion_pkg::*;
#(
    parameter int samples_per_word = default_samples_per_word,
    parameter int frame_words      = default_frame_words,
    parameter int motion_threshold = default_motion_threshold
)
(
    input  logic                                  pixel_clk,
    input  logic                                  reset,
    input  view_mode_t                            view_mode,
    // input stream
    input  logic [samples_per_word*sample_bits-1:0] pixel_in_data,
    input  logic                                  pixel_in_user,
    input  logic                                  pixel_in_last,
    input  logic                                  pixel_in_valid,
    output logic                                  pixel_in_ready,
    // output stream
    output logic [samples_per_word*sample_bits-1:0] pixel_out_data,
    output logic                                  pixel_out_user,
    output logic                                  pixel_out_last,
    output logic                                  pixel_out_valid,
    input  logic                                  pixel_out_ready
);

    localparam int word_bits = samples_per_word * sample_bits;

    // handshake and stall
    logic                 accept;
    logic                 advance;
    // stage B
    logic [word_bits-1:0] live_word;
    logic                 stage_user;
    logic                 stage_last;
    logic                 stage_valid;
    // store read and mask
    logic [word_bits-1:0] previous_word;
    logic [word_bits-1:0] motion_word;

    ////////////////////
    // pipeline blocks
    ////////////////////

    stream_ctrl #(
        .samples_per_word (samples_per_word)
    ) u_stream_ctrl (
        .pixel_clk       (pixel_clk),
        .reset           (reset),
        .pixel_in_data   (pixel_in_data),
        .pixel_in_user   (pixel_in_user),
        .pixel_in_last   (pixel_in_last),
        .pixel_in_valid  (pixel_in_valid),
        .pixel_out_valid (pixel_out_valid),
        .pixel_out_ready (pixel_out_ready),
        .pixel_in_ready  (pixel_in_ready),
        .accept          (accept),
        .advance         (advance),
        .live_word       (live_word),
        .stage_user      (stage_user),
        .stage_last      (stage_last),
        .stage_valid     (stage_valid)
    );

    frame_store #(
        .samples_per_word (samples_per_word),
        .frame_words      (frame_words)
    ) u_frame_store (
        .pixel_clk     (pixel_clk),
        .reset         (reset),
        .accept        (accept),
        .pixel_in_user (pixel_in_user),
        .pixel_in_data (pixel_in_data),
        .previous_word (previous_word)
    );

    frame_diff #(
        .samples_per_word (samples_per_word),
        .motion_threshold (motion_threshold)
    ) u_frame_diff (
        .live_word     (live_word),
        .previous_word (previous_word),
        .motion_word   (motion_word)
    );

    view_select #(
        .samples_per_word (samples_per_word)
    ) u_view_select (
        .pixel_clk       (pixel_clk),
        .reset           (reset),
        .advance         (advance),
        .view_mode       (view_mode),
        .live_word       (live_word),
        .previous_word   (previous_word),
        .motion_word     (motion_word),
        .stage_user      (stage_user),
        .stage_last      (stage_last),
        .stage_valid     (stage_valid),
        .pixel_out_data  (pixel_out_data),
        .pixel_out_user  (pixel_out_user),
        .pixel_out_last  (pixel_out_last),
        .pixel_out_valid (pixel_out_valid)
    );

endmodule

/* test/motion_detect_sva.sv */
`timescale 1ns/100ps

module motion_detect_sva
    import motion_pkg::*;
#(
    parameter int samples_per_word = default_samples_per_word
)
(
    input logic                                    pixel_clk,
    input logic                                    reset,
    input logic                                    pixel_in_ready,
    input logic [samples_per_word*sample_bits-1:0] pixel_out_data,
    input logic                                    pixel_out_user,
    input logic                                    pixel_out_last,
    input logic                                    pixel_out_valid,
    input logic                                    pixel_out_ready
);

    // output register comes out of reset empty
    a_valid_after_reset: assert property (@(posedge pixel_clk) reset |=> !pixel_out_valid)
        else $error("pixel_out_valid high in the cycle after reset");

    // held word must not move while downstream waits
    a_stable_on_stall: assert property (@(posedge pixel_clk) disable iff (reset)
        (pixel_out_valid && !pixel_out_ready) |=>
        (pixel_out_valid && $stable(pixel_out_data) &&
         $stable(pixel_out_user) && $stable(pixel_out_last)))
        else $error("output changed during a stall");

    // ready is the inverse of the global stall
    a_ready_rule: assert property (@(posedge pixel_clk) disable iff (reset)
        pixel_in_ready == (!pixel_out_valid || pixel_out_ready))
        else $error("pixel_in_ready does not match output empty or ready");

endmodule

/* test/tb_motion_detect.sv */
`timescale 1ns/100ps

module tb_motion_detect
    import motion_pkg::*;
();

    localparam int word_bits    = default_samples_per_word * sample_bits;
    localparam int max_vectors  = 64;
    // view, user, last, input word, expected word
    localparam int fields       = 5;
    localparam int accept_limit = 200;
    localparam int drain_limit  = 400;

    ////////////////////
    // clock, reset, dut ports
    ////////////////////

    logic                 pixel_clk = 1'b0;
    logic                 reset;
    view_mode_t           view_mode;
    logic [word_bits-1:0] pixel_in_data;
    logic                 pixel_in_user;
    logic                 pixel_in_last;
    logic                 pixel_in_valid;
    logic                 pixel_in_ready;
    logic [word_bits-1:0] pixel_out_data;
    logic                 pixel_out_user;
    logic                 pixel_out_last;
    logic                 pixel_out_valid;
    logic                 pixel_out_ready = 1'b0;

    // raw file image, then split per field
    logic [word_bits-1:0] vec_mem [max_vectors*fields];
    logic [1:0]           vec_view [max_vectors];
    logic                 vec_user [max_vectors];
    logic                 vec_last [max_vectors];
    logic [word_bits-1:0] vec_data [max_vectors];
    logic [word_bits-1:0] vec_expect [max_vectors];
    // last word of a frame closes one test
    logic                 vec_frame_end [max_vectors];
    int                   num_vectors = 0;

    // sender side
    int          sent_count = 0;
    bit          timed_out = 1'b0;
    // receiver side
    int recv_count = 0;
    int words_checked = 0;
    int mismatch_count = 0;
    int tests_done = 0;
    int tests_failed = 0;
    int test_errors = 0;
    int test_words = 0;
    int test_index = 1;

    // 4 ns period
    always #2 pixel_clk = ~pixel_clk;

    motion_detect_top #(
        .samples_per_word (default_samples_per_word),
        .frame_words      (default_frame_words),
        .motion_threshold (default_motion_threshold)
    ) uut (
        .pixel_clk       (pixel_clk),
        .reset           (reset),
        .view_mode       (view_mode),
        .pixel_in_data   (pixel_in_data),
        .pixel_in_user   (pixel_in_user),
        .pixel_in_last   (pixel_in_last),
        .pixel_in_valid  (pixel_in_valid),
        .pixel_in_ready  (pixel_in_ready),
        .pixel_out_data  (pixel_out_data),
        .pixel_out_user  (pixel_out_user),
        .pixel_out_last  (pixel_out_last),
        .pixel_out_valid (pixel_out_valid),
        .pixel_out_ready (pixel_out_ready)
    );

    // handshake checks ride along inside the top level
    bind motion_detect_top motion_detect_sva #(
        .samples_per_word (samples_per_word)
    ) u_sva (
        .pixel_clk       (pixel_clk),
        .reset           (reset),
        .pixel_in_ready  (pixel_in_ready),
        .pixel_out_data  (pixel_out_data),
        .pixel_out_user  (pixel_out_user),
        .pixel_out_last  (pixel_out_last),
        .pixel_out_valid (pixel_out_valid),
        .pixel_out_ready (pixel_out_ready)
    );

    ////////////////////
    // helpers
    ////////////////////

    function automatic string view_name(input logic [1:0] code);
        case (code)
            2'd1:    return "previous";
            2'd2:    return "motion";
            default: return "live";
        endcase
    endfunction

    task automatic load_vectors();
        int k;
        // all ones in the view field marks the end of the file
        for (k = 0; k < max_vectors * fields; k++)
            vec_mem[k] = '1;
        $readmemh("test/motion_testdata.txt", vec_mem);
        num_vectors = 0;
        while (num_vectors < max_vectors && vec_mem[num_vectors*fields] != '1)
        begin
            vec_view[num_vectors]   = vec_mem[num_vectors*fields][1:0];
            vec_user[num_vectors]   = vec_mem[num_vectors*fields+1][0];
            vec_last[num_vectors]   = vec_mem[num_vectors*fields+2][0];
            vec_data[num_vectors]   = vec_mem[num_vectors*fields+3];
            vec_expect[num_vectors] = vec_mem[num_vectors*fields+4];
            num_vectors++;
        end
        // a frame ends right before the next user word
        for (k = 0; k < num_vectors; k++)
            vec_frame_end[k] = (k == num_vectors - 1) || vec_mem[(k+1)*fields+1][0];
    endtask

    // one input word, with an optional random gap in front
    task automatic send_word(input int idx);
        int  gap_cycles;
        int  g;
        int  cycles;
        bit  accepted;
        gap_cycles = 0;
        if ($urandom_range(0, 3) == 0)
            gap_cycles = $urandom_range(1, 3);
        for (g = 0; g < gap_cycles; g++)
        begin
            pixel_in_valid <= 1'b0;
            @(posedge pixel_clk);
        end
        pixel_in_data  <= vec_data[idx];
        pixel_in_user  <= vec_user[idx];
        pixel_in_last  <= vec_last[idx];
        pixel_in_valid <= 1'b1;
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < accept_limit)
        begin
            @(posedge pixel_clk);
            cycles++;
            if (pixel_in_ready)
                accepted = 1'b1;
        end
        if (accepted)
            sent_count++;
        else
        begin
            $display("Timeout: word %0d was not accepted within %0d cycles", idx, accept_limit);
            timed_out = 1'b1;
        end
    endtask

    // every accepted word has come out the other side
    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (recv_count != sent_count && cycles < drain_limit)
        begin
            @(posedge pixel_clk);
            cycles++;
        end
        if (recv_count != sent_count)
        begin
            $display("Timeout: output stalled with %0d of %0d words received",
                     recv_count, sent_count);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_output();
        int idx;
        idx = recv_count;
        if (idx >= num_vectors)
        begin
            $display("extra output word %0d arrived after the last expected word", idx);
            mismatch_count++;
        end
        else
        begin
            words_checked++;
            test_words++;
            if (pixel_out_data !== vec_expect[idx])
            begin
                $display("Error: pixel_out_data word %0d expected %h got %h",
                         idx, vec_expect[idx], pixel_out_data);
                test_errors++;
                mismatch_count++;
            end
            if (pixel_out_user !== vec_user[idx])
            begin
                $display("Error: pixel_out_user word %0d expected %h got %h",
                         idx, vec_user[idx], pixel_out_user);
                test_errors++;
                mismatch_count++;
            end
            if (pixel_out_last !== vec_last[idx])
            begin
                $display("Error: pixel_out_last word %0d expected %h got %h",
                         idx, vec_last[idx], pixel_out_last);
                test_errors++;
                mismatch_count++;
            end
            // frame done, report it
            if (vec_frame_end[idx])
            begin
                $display("test %0d, %s view: %0d words, %0d errors",
                         test_index, view_name(vec_view[idx]), test_words, test_errors);
                tests_done++;
                if (test_errors != 0)
                    tests_failed++;
                test_errors = 0;
                test_words = 0;
                test_index++;
            end
        end
        recv_count <= recv_count + 1;
    endtask

    ////////////////////
    // output side
    ////////////////////

    // collect on handshake, random back-pressure
    always @(posedge pixel_clk)
    begin
        if (reset)
            pixel_out_ready <= 1'b0;
        else
        begin
            if (pixel_out_valid && pixel_out_ready)
                check_output();
            pixel_out_ready <= ($urandom_range(0, 3) != 0);
        end
    end

    ////////////////////
    // input side and run control
    ////////////////////

    initial
    begin
        void'($urandom(32'h59ed_adbe));
        reset          <= 1'b1;
        view_mode      <= VIEW_LIVE;
        pixel_in_data  <= '0;
        pixel_in_user  <= 1'b0;
        pixel_in_last  <= 1'b0;
        pixel_in_valid <= 1'b0;
        load_vectors();
        repeat (8) @(posedge pixel_clk);
        reset <= 1'b0;
        for (int i = 0; i < num_vectors && !timed_out; i++)
        begin
            // view only changes with the pipe empty
            if (vec_view[i] != view_mode)
            begin
                // no new word while the pipe empties
                pixel_in_valid <= 1'b0;
                wait_for_drain();
                view_mode <= view_mode_t'(vec_view[i]);
            end
            if (!timed_out)
                send_word(i);
        end
        pixel_in_valid <= 1'b0;
        if (!timed_out)
            wait_for_drain();
        if (num_vectors == 0)
            $display("no test vectors found in the data file");
        $display("words checked %0d of %0d, tests %0d, tests failed %0d, errors %0d",
                 words_checked, num_vectors, tests_done, tests_failed, mismatch_count);
        if (timed_out || mismatch_count != 0 || num_vectors == 0 ||
            words_checked != num_vectors)
            $display("SOME TESTS FAILED");
        else
            $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* test/motion_testdata.txt */
// columns: view user last input_word expected_word, all hex
// view 0 live, 1 previous frame, 2 motion mask with threshold 10
0 1 0 10203040 10203040
0 0 1 50607080 50607080
0 0 0 90a0b0c0 90a0b0c0
0 0 1 d0e0f000 d0e0f000
1 1 0 20202020 10203040
1 0 1 80808080 50607080
1 0 0 00ff00ff 90a0b0c0
1 0 1 64646464 d0e0f000
2 1 0 2a2b1615 00ff00ff
2 0 1 80ff008a 00ffff00
2 1 0 2a2b1615 00000000
2 0 1 75f50b94 ff00ff00
2 0 0 0bf40af5 ffff0000
2 0 1 646e5900 0000ffff

/* flist.f */
source/motion_pkg.sv
source/stream_ctrl.sv
source/frame_store.sv
source/frame_diff.sv
source/view_select.sv
source/motion_detect_top.sv
test/motion_detect_sva.sv
test/tb_motion_detect.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_motion_detect -f flist.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
